//--- vga_config.svh
/*
  vga gain-control configuration
  clock rates, amplifier count and command buffer depth
*/
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// system clock for the whole command path, in Hz
`define VGA_CLK_FREQ 100000000

// serial clock to the amplifiers, in Hz
// with a 100 MHz system clock this is a divide by 10
// so sck toggles every 5 clk cycles
`define VGA_SPI_CLK_FREQ 10000000

// LMH6401 parts sharing sck and sdi
// each one gets its own chip select
`define VGA_NUM_CHANNELS 4

// commands buffered ahead of the write filter
// keep it a power of two for cheap pointer wrap
`define VGA_FIFO_DEPTH 4

`endif

//--- vga_pkg.sv
/*
  vga_pkg
  shared types for the LMH6401 gain-control path
*/
`include "vga_config.svh"

package vga_pkg;

  // amplifier index, selects one chip select line
  typedef logic [$clog2(`VGA_NUM_CHANNELS)-1:0] chan_t;

  // LMH6401 serial word
  // [15] read flag, [14:8] register address, [7:0] value
  typedef logic [15:0] reg_word_t;

  // command word, channel on top of the register word
  typedef logic [$bits(chan_t)+15:0] cmd_t;

  // serial writer sequencing
  typedef enum logic [1:0] {
    idle,
    sending,
    finish
  } spi_state_t;

endpackage

//--- gain_cmd_fifo.sv
/*
  gain_cmd_fifo
  small circular command buffer with valid/ready on both sides
*/
`include "vga_config.svh"

module gain_cmd_fifo (
  input  logic          clk,
  input  logic          reset,
  input  logic          in_valid,
  input  vga_pkg::cmd_t in_cmd,
  output logic          in_ready,
  output logic          out_valid,
  output vga_pkg::cmd_t out_cmd,
  input  logic          out_ready
);

  localparam int PTR_W = (`VGA_FIFO_DEPTH > 1) ? $clog2(`VGA_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(`VGA_FIFO_DEPTH + 1);

  // storage, payload only
  vga_pkg::cmd_t mem [`VGA_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // full when every entry holds a command
  assign in_ready  = count != CNT_W'(`VGA_FIFO_DEPTH);
  assign out_valid = count != '0;
  // head of queue presented directly
  assign out_cmd   = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_cmd;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`VGA_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`VGA_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- gain_write_filter.sv
/*
  gain_write_filter
  remembers the last word sent per channel and drops repeated writes
*/
`include "vga_config.svh"

module gain_write_filter (
  input  logic          clk,
  input  logic          reset,
  input  logic          in_valid,
  input  vga_pkg::cmd_t in_cmd,
  output logic          in_ready,
  output logic          out_valid,
  output vga_pkg::cmd_t out_cmd,
  input  logic          out_ready
);

  // one-entry holding register
  logic          hold_valid;
  vga_pkg::cmd_t hold_cmd;

  // last word written per channel, as it went out on the wire
  vga_pkg::reg_word_t           cache_word [`VGA_NUM_CHANNELS];
  logic [`VGA_NUM_CHANNELS-1:0] cache_valid;

  vga_pkg::chan_t     hold_chan;
  vga_pkg::reg_word_t sent_word;
  logic               drop;
  logic               take;

  assign hold_chan = hold_cmd[$bits(vga_pkg::cmd_t)-1:16];
  // read flag cleared, this is the form the amplifier actually sees
  assign sent_word = {1'b0, hold_cmd[14:0]};

  // compare against the registered cache
  // a word handed to the writer on the previous edge is already recorded
  assign drop = hold_valid && cache_valid[hold_chan] &&
                (cache_word[hold_chan] == sent_word);

  assign out_valid = hold_valid && !drop;
  assign out_cmd   = {hold_chan, sent_word};
  assign take      = out_valid && out_ready;

  // room when empty, or when the held entry leaves this cycle
  assign in_ready = !hold_valid || drop || take;

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      hold_valid <= 1'b1;
    end else if (drop || take) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      hold_cmd <= in_cmd;
    end
  end

  // cache only learns words the writer has accepted
  always_ff @(posedge clk) begin
    if (take) begin
      cache_word[hold_chan] <= sent_word;
    end
  end

  // first write to each channel always goes through
  always_ff @(posedge clk) begin
    if (reset) begin
      cache_valid <= '0;
    end else if (take) begin
      cache_valid[hold_chan] <= 1'b1;
    end
  end

endmodule

//--- lmh6401_spi.sv
/*
  lmh6401_spi
  write-only serial link to a bank of LMH6401 amplifiers with shared sck/sdi
*/
`include "vga_config.svh"

module lmh6401_spi (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cmd_valid,
  input  vga_pkg::cmd_t                cmd,
  output logic                         cmd_ready,
  output logic                         sck,
  output logic                         sdi,
  output logic [`VGA_NUM_CHANNELS-1:0] cs_n
);

  // sck toggles every half period of the divided clock
  localparam int CLK_DIV  = `VGA_CLK_FREQ / `VGA_SPI_CLK_FREQ;
  localparam int HALF_DIV = CLK_DIV / 2;
  localparam int CNT_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
  localparam logic [CNT_W-1:0] DIV_MAX = CNT_W'(HALF_DIV - 1);

  logic [CNT_W-1:0] div_count;
  logic             sck_fall;

  vga_pkg::spi_state_t state;
  vga_pkg::reg_word_t  shift_reg;
  vga_pkg::chan_t      addr;
  logic [3:0]          bits_sent;

  // free-running divider with sck low out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      sck       <= 1'b0;
      div_count <= '0;
    end else if (div_count == DIV_MAX) begin
      sck       <= ~sck;
      div_count <= '0;
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  // high on the clk edge where sck goes from 1 to 0
  // data and chip select change here so the slave sees them settled
  // by the next rising edge
  assign sck_fall = sck && (div_count == DIV_MAX);

  // new frames only while idle
  assign cmd_ready = state == vga_pkg::idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= vga_pkg::idle;
      bits_sent <= '0;
      cs_n      <= '1;
      sdi       <= 1'b0;
    end else begin
      case (state)
        vga_pkg::idle: begin
          if (cmd_valid) begin
            state     <= vga_pkg::sending;
            bits_sent <= '0;
          end
        end
        vga_pkg::sending: begin
          if (sck_fall) begin
            // select drops together with the first bit
            cs_n[addr] <= 1'b0;
            sdi        <= shift_reg[15];
            bits_sent  <= bits_sent + 1'b1;
            if (bits_sent == 4'd15) begin
              state <= vga_pkg::finish;
            end
          end
        end
        vga_pkg::finish: begin
          // release the select and go idle one falling edge after the last bit
          if (sck_fall) begin
            cs_n[addr] <= 1'b1;
            sdi        <= 1'b0;
            state      <= vga_pkg::idle;
          end
        end
        default: begin
          state <= vga_pkg::idle;
          cs_n  <= '1;
        end
      endcase
    end
  end

  // channel and shift register latched when a frame starts
  always_ff @(posedge clk) begin
    if (state == vga_pkg::idle && cmd_valid) begin
      addr <= cmd[$bits(vga_pkg::cmd_t)-1:16];
      // read flag forced low since the parts are never read back
      shift_reg <= {1'b0, cmd[14:0]};
    end else if (state == vga_pkg::sending && sck_fall) begin
      // msb first
      shift_reg <= {shift_reg[14:0], 1'b0};
    end
  end

endmodule

//--- vga_gain_ctrl.sv
/*
  vga_gain_ctrl
  command FIFO, repeat filter and SPI writer for the LMH6401 bank
*/
`include "vga_config.svh"

module vga_gain_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cmd_valid,
  input  vga_pkg::cmd_t                cmd,
  output logic                         cmd_ready,
  output logic                         sck,
  output logic                         sdi,
  output logic [`VGA_NUM_CHANNELS-1:0] cs_n
);

  // FIFO to filter
  logic          fifo_valid;
  vga_pkg::cmd_t fifo_cmd;
  logic          fifo_ready;

  // filter to serial writer
  logic          spi_valid;
  vga_pkg::cmd_t spi_cmd;
  logic          spi_ready;

  // absorbs bursts while the serial link is busy
  gain_cmd_fifo fifo0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (cmd_valid),
    .in_cmd    (cmd),
    .in_ready  (cmd_ready),
    .out_valid (fifo_valid),
    .out_cmd   (fifo_cmd),
    .out_ready (fifo_ready)
  );

  // skips writes that would not change the amplifier
  gain_write_filter filter0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (fifo_valid),
    .in_cmd    (fifo_cmd),
    .in_ready  (fifo_ready),
    .out_valid (spi_valid),
    .out_cmd   (spi_cmd),
    .out_ready (spi_ready)
  );

  lmh6401_spi spi0 (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (spi_valid),
    .cmd       (spi_cmd),
    .cmd_ready (spi_ready),
    .sck       (sck),
    .sdi       (sdi),
    .cs_n      (cs_n)
  );

endmodule

//--- vga_spi_monitor.sv
/*
  vga_spi_monitor
  rebuilds LMH6401 frames from sck, sdi and the per-channel chip selects
*/
`include "vga_config.svh"

module vga_spi_monitor (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         sck,
  input  logic                         sdi,
  input  logic [`VGA_NUM_CHANNELS-1:0] cs_n,
  output logic                         frame_done,
  output vga_pkg::chan_t               frame_chan,
  output vga_pkg::reg_word_t           frame_word,
  output logic [4:0]                   frame_bits
);
  timeunit 1ns;
  timeprecision 1ps;

  logic                         sck_q;
  logic [`VGA_NUM_CHANNELS-1:0] cs_q;
  logic [`VGA_NUM_CHANNELS-1:0] cs_rise;
  vga_pkg::reg_word_t           shift;
  logic [4:0]                   bit_count;

  // index of the lowest set bit, the mask is one-hot in practice
  function automatic vga_pkg::chan_t lowest_bit(input logic [`VGA_NUM_CHANNELS-1:0] mask);
    vga_pkg::chan_t idx;
    idx = '0;
    for (int i = `VGA_NUM_CHANNELS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = vga_pkg::chan_t'(i);
      end
    end
    return idx;
  endfunction

  // a chip select going high closes the frame on that channel
  assign cs_rise = cs_n & ~cs_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q      <= 1'b0;
      cs_q       <= '1;
      frame_done <= 1'b0;
      frame_chan <= '0;
      frame_word <= '0;
      frame_bits <= '0;
      shift      <= '0;
      bit_count  <= '0;
    end else begin
      sck_q      <= sck;
      cs_q       <= cs_n;
      frame_done <= 1'b0;
      // slave side, sample sdi on rising sck while any part is selected
      if (sck && !sck_q && cs_n != '1) begin
        shift     <= {shift[14:0], sdi};
        bit_count <= bit_count + 5'd1;
      end
      if (cs_rise != '0) begin
        frame_done <= 1'b1;
        frame_chan <= lowest_bit(cs_rise);
        frame_word <= shift;
        frame_bits <= bit_count;
        bit_count  <= '0;
      end
    end
  end

endmodule

//--- tb_vga_gain_ctrl.sv
/*
  tb_vga_gain_ctrl
  drives gain commands into the FIFO/filter/SPI path and checks the serial frames
*/
`include "vga_config.svh"

module tb_vga_gain_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  // watchdog budget of about one frame time per command plus slack
  localparam int CMD_COUNT      = 16;
  localparam int CYCLES_PER_CMD = 200;
  localparam int MAX_CYCLES     = CMD_COUNT * CYCLES_PER_CMD + 800;
  // quiet stretch after the last frame so a stray frame would still start inside it
  localparam int QUIET_CYCLES   = 60;
  localparam int CHAN_HI        = $bits(vga_pkg::cmd_t) - 1;

  logic                         clk;
  logic                         reset;
  logic                         cmd_valid;
  vga_pkg::cmd_t                cmd;
  logic                         cmd_ready;
  logic                         sck;
  logic                         sdi;
  logic [`VGA_NUM_CHANNELS-1:0] cs_n;

  logic                         frame_done;
  vga_pkg::chan_t               frame_chan;
  vga_pkg::reg_word_t           frame_word;
  logic [4:0]                   frame_bits;

  // reference model updated only by the checker process
  vga_pkg::cmd_t                exp_q [$];
  vga_pkg::reg_word_t           last_word [`VGA_NUM_CHANNELS];
  logic [`VGA_NUM_CHANNELS-1:0] last_valid;
  int                           frames_seen;
  int                           stall_cycles;

  int check_errors;
  int frame_errors;
  int select_errors;
  int tests_run;
  int tests_failed;
  int cycle_count;
  int seed;

  vga_gain_ctrl dut0 (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .sck       (sck),
    .sdi       (sdi),
    .cs_n      (cs_n)
  );

  vga_spi_monitor mon0 (
    .clk        (clk),
    .reset      (reset),
    .sck        (sck),
    .sdi        (sdi),
    .cs_n       (cs_n),
    .frame_done (frame_done),
    .frame_chan (frame_chan),
    .frame_word (frame_word),
    .frame_bits (frame_bits)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d frames never arrived", MAX_CYCLES, exp_q.size());
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // sck and sdi are shared, so only one amplifier may be listening
  assert property (@(posedge clk) disable iff (reset) $onehot0(~cs_n))
    else begin
      $display("error at %0t: more than one chip select low, cs_n=%b", $time, cs_n);
      select_errors++;
    end

  function automatic int total_errors();
    return check_errors + frame_errors + select_errors;
  endfunction

  task automatic value_mismatch(input string name, input string expected, input string actual);
    $display("FAIL %0t %s expected %s got %s", $time, name, expected, actual);
  endtask

  // filter rule applied to the wire form with the read flag cleared
  task automatic model_accept(input vga_pkg::cmd_t c);
    vga_pkg::chan_t     ch;
    vga_pkg::reg_word_t sent;
    ch   = c[CHAN_HI:16];
    sent = {1'b0, c[14:0]};
    if (!(last_valid[ch] && last_word[ch] == sent)) begin
      exp_q.push_back({ch, sent});
      last_word[ch]  = sent;
      last_valid[ch] = 1'b1;
    end
  endtask

  task automatic check_frame();
    vga_pkg::cmd_t want;
    frames_seen++;
    assert (frame_bits == 5'd16) else begin
      value_mismatch("frame_bits", "16", $sformatf("%0d", frame_bits));
      frame_errors++;
    end
    assert (exp_q.size() != 0) else begin
      $display("error at %0t: frame on channel %0d with no command behind it", $time, frame_chan);
      frame_errors++;
    end
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      assert (frame_chan == want[CHAN_HI:16]) else begin
        value_mismatch("cs_n channel", $sformatf("%0d", want[CHAN_HI:16]),
                       $sformatf("%0d", frame_chan));
        frame_errors++;
      end
      assert (frame_word == want[15:0]) else begin
        value_mismatch("sdi word", $sformatf("%h", want[15:0]), $sformatf("%h", frame_word));
        frame_errors++;
      end
    end
  endtask

  // handshake and frame outputs come from flops and are stable at the rising edge
  always @(posedge clk) begin
    if (reset) begin
      last_valid = '0;
    end else begin
      if (frame_done) begin
        check_frame();
      end
      if (cmd_valid && cmd_ready) begin
        model_accept(cmd);
      end
      if (cmd_valid && !cmd_ready) begin
        stall_cycles++;
      end
    end
  end

  // holds cmd until the FIFO takes it and returns on the falling edge after the transfer
  task automatic send_cmd(input vga_pkg::chan_t ch, input vga_pkg::reg_word_t word);
    cmd_valid = 1'b1;
    cmd       = {ch, word};
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    cmd_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // waits for all expected frames and then a quiet stretch with every chip select high
  task automatic wait_drain();
    int quiet;
    cmd_valid = 1'b0;
    quiet     = 0;
    while (exp_q.size() != 0 || quiet < QUIET_CYCLES) begin
      @(negedge clk);
      if (exp_q.size() == 0 && cs_n == '1) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic expect_frames(input int expected);
    assert (frames_seen == expected) else begin
      value_mismatch("frames_seen", $sformatf("%0d", expected), $sformatf("%0d", frames_seen));
      check_errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    int errors;
    errors = total_errors() - errors_before;
    tests_run++;
    if (errors == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors);
    end
  endtask

  initial begin
    int                 errors_before;
    int                 seen_before;
    int                 stalls_before;
    int                 gap;
    vga_pkg::chan_t     ch;
    vga_pkg::reg_word_t word;
    seed      = 32'hab46;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    errors_before = total_errors();
    assert (cs_n == '1) else begin
      value_mismatch("cs_n", "all ones", $sformatf("%b", cs_n));
      check_errors++;
    end
    assert (sck == 1'b0) else begin
      value_mismatch("sck", "0", $sformatf("%b", sck));
      check_errors++;
    end
    assert (cmd_ready == 1'b1) else begin
      value_mismatch("cmd_ready", "1", $sformatf("%b", cmd_ready));
      check_errors++;
    end
    finish_test("reset state", errors_before);

    // read flag set on input must reach the wire cleared
    errors_before = total_errors();
    seen_before   = frames_seen;
    word          = 16'h8000 | 16'($random(seed));
    send_cmd(vga_pkg::chan_t'(1), word);
    wait_drain();
    expect_frames(seen_before + 1);
    finish_test("single write", errors_before);

    // rotating channels where gaps of 0 or 1 keep cmd_valid high back to back
    // five fresh random words give five frames
    errors_before = total_errors();
    seen_before   = frames_seen;
    ch            = vga_pkg::chan_t'($random(seed));
    for (int i = 0; i < 5; i++) begin
      send_cmd(ch, 16'($random(seed)));
      ch  = ch + 1'b1;
      gap = $random(seed) & 3;
      if (gap > 1) begin
        idle_cycles(gap);
      end
    end
    wait_drain();
    expect_frames(seen_before + 5);
    finish_test("ordering and chip select", errors_before);

    errors_before = total_errors();
    word          = 16'($random(seed)) & 16'h7fff;
    send_cmd(vga_pkg::chan_t'(2), word);
    wait_drain();
    seen_before = frames_seen;
    send_cmd(vga_pkg::chan_t'(2), word);
    wait_drain();
    expect_frames(seen_before);
    send_cmd(vga_pkg::chan_t'(2), word ^ 16'h0001);
    wait_drain();
    expect_frames(seen_before + 1);
    finish_test("repeat filtering", errors_before);

    // long burst overruns the FIFO while the writer is busy
    // seven commands with one repeat leave six frames
    errors_before = total_errors();
    seen_before   = frames_seen;
    stalls_before = stall_cycles;
    for (int i = 0; i < 7; i++) begin
      if (i == 3) begin
        // same write again with the read flag flipped is dropped by the filter
        word = word ^ 16'h8000;
      end else begin
        ch   = vga_pkg::chan_t'($random(seed));
        word = 16'($random(seed));
      end
      send_cmd(ch, word);
    end
    wait_drain();
    assert (stall_cycles > stalls_before) else begin
      $display("error at %0t: cmd_ready never dropped while the burst was held", $time);
      check_errors++;
    end
    expect_frames(seen_before + 6);
    finish_test("back-pressure", errors_before);

    $display("%0d tests, %0d failed, %0d errors, %0d frames checked",
             tests_run, tests_failed, total_errors(), frames_seen);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
vga_pkg.sv
gain_cmd_fifo.sv
gain_write_filter.sv
lmh6401_spi.sv
vga_gain_ctrl.sv
vga_spi_monitor.sv
tb_vga_gain_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# builds the gain-control testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f \
  --top-module tb_vga_gain_ctrl -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^ALL TESTS PASSED$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
